// ==== simplebus_subsystem.f ====
verilog/simplebus_pkg.sv
verilog/simplebus_if.sv
verilog/simplebus_interconnect.sv
verilog/bus_command_port.sv
verilog/register_bank.sv
verilog/scratch_ram.sv
verilog/simplebus_subsystem.sv
test/tb_clock_gen.sv
test/tb_simplebus_subsystem.sv

// ==== Bender.yml ====
package:
  name: simplebus_subsystem

sources:
  - files:
      - verilog/simplebus_pkg.sv
      - verilog/simplebus_if.sv
      - verilog/simplebus_interconnect.sv
      - verilog/bus_command_port.sv
      - verilog/register_bank.sv
      - verilog/scratch_ram.sv
      - verilog/simplebus_subsystem.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_simplebus_subsystem.sv

// ==== test/tb_simplebus_subsystem.sv ====
// Testbench for the Simplebus subsystem, driving the four-phase command port.
// Keeps a model of the register bank and RAM and checks every read against it.
// Handshake rules on the cmd_* ports are watched by concurrent assertions.

`default_nettype none

module tb_simplebus_subsystem;

        localparam int ACK_TIMEOUT   = 20;
        localparam int RESET_TIMEOUT = 40;
        localparam int RAM_OPS       = 40;
        localparam logic [31:0] RAM_BASE   = 32'h0000_1000;
        localparam logic [31:0] ERROR_WORD = 32'hdead_beef;

        logic        clock;
        logic        rst;
        logic        cmd_req;
        logic        cmd_write;
        logic [31:0] cmd_address;
        logic [31:0] cmd_write_data;
        logic        cmd_ack;
        logic [31:0] cmd_read_data;

        logic [31:0] lcg_state = 32'h6031;
        logic [31:0] reg_model [7];
        logic [31:0] ram_model [256];
        int          write_count;
        int          ram_written [$];

        tb_clock_gen u_clock_gen (
                .clock (clock),
                .rst   (rst)
        );

        simplebus_subsystem u_dut (
                .clock          (clock),
                .rst            (rst),
                .cmd_req        (cmd_req),
                .cmd_write      (cmd_write),
                .cmd_address    (cmd_address),
                .cmd_write_data (cmd_write_data),
                .cmd_ack        (cmd_ack),
                .cmd_read_data  (cmd_read_data)
        );

        task automatic abort_run();
                $display("SIMULATION FAILED");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] got);
                assert (got === expected) else begin
                        $display("Fail at time %0t: %s expected %h got %h",
                                 $time, name, expected, got);
                        abort_run();
                end
        endtask

        // Numerical Recipes LCG constants
        function automatic logic [31:0] next_random();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        task automatic wait_for_ack(input logic level);
                int cycles;
                cycles = 0;
                do begin
                        @(posedge clock);
                        cycles++;
                end while (cmd_ack !== level && cycles < ACK_TIMEOUT);
                if (cmd_ack !== level) begin
                        $display("Timeout at time %0t: cmd_ack did not go to %b in %0d cycles",
                                 $time, level, ACK_TIMEOUT);
                        abort_run();
                end
        endtask

        task automatic do_write(input logic [31:0] address, input logic [31:0] data);
                @(posedge clock);
                cmd_write      <= 1'b1;
                cmd_address    <= address;
                cmd_write_data <= data;
                cmd_req        <= 1'b1;
                wait_for_ack(1'b1);
                cmd_req <= 1'b0;
                wait_for_ack(1'b0);
        endtask

        task automatic do_read(input logic [31:0] address, output logic [31:0] data);
                @(posedge clock);
                cmd_write   <= 1'b0;
                cmd_address <= address;
                cmd_req     <= 1'b1;
                wait_for_ack(1'b1);
                data = cmd_read_data;
                cmd_req <= 1'b0;
                wait_for_ack(1'b0);
        endtask

        task automatic read_and_check(input string name, input logic [31:0] address,
                                      input logic [31:0] expected);
                logic [31:0] data;
                do_read(address, data);
                check_value(name, expected, data);
        endtask

        // Reads back every register word and every RAM word written so far
        task automatic check_all_contents();
                for (int i = 0; i < 7; i++) begin
                        read_and_check("register word", 32'(i * 4), reg_model[i]);
                end
                read_and_check("write counter", 32'h0000_001c, 32'(write_count));
                foreach (ram_written[k]) begin
                        read_and_check("ram word", RAM_BASE + 32'(ram_written[k] * 4),
                                       ram_model[ram_written[k]]);
                end
        endtask

        a_ack_needs_req: assert property (
                @(posedge clock) disable iff (rst) $rose(cmd_ack) |-> cmd_req
        ) else begin
                $display("Error at time %0t: cmd_ack rose while cmd_req was low", $time);
                abort_run();
        end

        a_ack_falls: assert property (
                @(posedge clock) disable iff (rst)
                $fell(cmd_req) |-> ##[1:ACK_TIMEOUT] !cmd_ack
        ) else begin
                $display("Error at time %0t: cmd_ack stayed high after cmd_req fell", $time);
                abort_run();
        end

        a_read_data_stable: assert property (
                @(posedge clock) disable iff (rst)
                (cmd_ack && $past(cmd_ack) && !cmd_write) |-> $stable(cmd_read_data)
        ) else begin
                $display("Fail at time %0t: cmd_read_data expected %h got %h",
                         $time, $past(cmd_read_data), cmd_read_data);
                abort_run();
        end

        initial begin
                int          cycles;
                int          index;
                logic [31:0] data;

                cmd_req        <= 1'b0;
                cmd_write      <= 1'b0;
                cmd_address    <= '0;
                cmd_write_data <= '0;
                write_count = 0;
                for (int i = 0; i < 7; i++) begin
                        reg_model[i] = '0;
                end

                cycles = 0;
                do begin
                        @(posedge clock);
                        cycles++;
                end while (rst !== 1'b0 && cycles < RESET_TIMEOUT);
                if (rst !== 1'b0) begin
                        $display("Timeout at time %0t: reset was never released", $time);
                        abort_run();
                end
                @(posedge clock);
                check_value("cmd_ack", 32'd0, 32'(cmd_ack));

                // Register words 0 to 6, then an ignored write to the counter word
                for (int i = 0; i < 7; i++) begin
                        data = next_random();
                        do_write(32'(i * 4), data);
                        reg_model[i] = data;
                        write_count++;
                end
                do_write(32'h0000_001c, next_random());
                write_count++;
                check_all_contents();

                // Random RAM traffic, each read hitting a word already written
                for (int n = 0; n < RAM_OPS; n++) begin
                        index = int'(next_random() % 256);
                        data  = next_random();
                        do_write(RAM_BASE + 32'(index * 4), data);
                        ram_model[index] = data;
                        ram_written.push_back(index);
                        index = ram_written[next_random() % ram_written.size()];
                        read_and_check("ram word", RAM_BASE + 32'(index * 4), ram_model[index]);
                end

                read_and_check("unmapped read", 32'h0000_0800, ERROR_WORD);
                read_and_check("unmapped read", 32'h8000_0000, ERROR_WORD);
                do_write(32'h0000_0800, next_random());
                do_write(32'h8000_1000, next_random());
                check_all_contents();

                $display("SIMULATION PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Testbench clock and reset source for the Simplebus subsystem.
// Clock period is 4 time units; rst is held high for the first 16 cycles.

`default_nettype none

module tb_clock_gen (
        output logic clock,
        output logic rst
);
        localparam int HALF_PERIOD  = 2;
        localparam int RESET_CYCLES = 16;

        initial begin
                clock = 1'b0;
                forever #HALF_PERIOD clock = ~clock;
        end

        initial begin
                rst = 1'b1;
                repeat (RESET_CYCLES) @(posedge clock);
                rst <= 1'b0;
        end

endmodule

`default_nettype wire

// ==== verilog/simplebus_subsystem.sv ====
// Top level of the Simplebus peripheral subsystem.
// An outside agent drives the four-phase cmd_* port; the command port
// masters the interconnect, which serves the register bank and the RAM.

`default_nettype none

module simplebus_subsystem (
        input  logic                                clock,
        input  logic                                rst,
        input  logic                                cmd_req,
        input  logic                                cmd_write,
        input  logic [simplebus_pkg::BUS_WIDTH-1:0] cmd_address,
        input  logic [simplebus_pkg::BUS_WIDTH-1:0] cmd_write_data,
        output logic                                cmd_ack,
        output logic [simplebus_pkg::BUS_WIDTH-1:0] cmd_read_data
);
        import simplebus_pkg::*;

        simplebus_if master_bus ();
        simplebus_if slave_bus [SLAVE_COUNT] ();

        bus_command_port u_command_port (
                .clock          (clock),
                .rst            (rst),
                .cmd_req        (cmd_req),
                .cmd_write      (cmd_write),
                .cmd_address    (cmd_address),
                .cmd_write_data (cmd_write_data),
                .cmd_ack        (cmd_ack),
                .cmd_read_data  (cmd_read_data),
                .bus            (master_bus)
        );

        simplebus_interconnect u_interconnect (
                .clock  (clock),
                .rst    (rst),
                .master (master_bus),
                .slaves (slave_bus)
        );

        // Slot order follows the package address map
        register_bank u_register_bank (
                .clock (clock),
                .rst   (rst),
                .bus   (slave_bus[0])
        );

        scratch_ram u_scratch_ram (
                .clock (clock),
                .rst   (rst),
                .bus   (slave_bus[1])
        );

endmodule

`default_nettype wire

// ==== verilog/scratch_ram.sv ====
// Single-port scratch RAM slave on Simplebus, 256 words deep.
// Reads return one cycle after the strobe; writes complete on the strobe.

`default_nettype none

module scratch_ram (
        input logic clock,
        input logic rst,
        simplebus_if.slave bus
);
        import simplebus_pkg::*;

        logic [BUS_WIDTH-1:0]       mem [RAM_DEPTH];
        logic [RAM_INDEX_WIDTH-1:0] index;
        logic [BUS_WIDTH-1:0]       read_data_q;
        logic                       read_valid_q;

        // Word index from byte address bits 9 to 2
        assign index = bus.sb_address[2 +: RAM_INDEX_WIDTH];

        always_ff @(posedge clock) begin
                if (bus.sb_write_strobe) begin
                        mem[index] <= bus.sb_write_data;
                end
                if (bus.sb_read_strobe) begin
                        read_data_q <= mem[index];
                end
        end

        always_ff @(posedge clock) begin
                if (rst) begin
                        read_valid_q <= 1'b0;
                end else begin
                        read_valid_q <= bus.sb_read_strobe;
                end
        end

        // Zero outside valid cycles keeps the OR merge clean
        assign bus.sb_read_valid = read_valid_q;
        assign bus.sb_read_data  = read_valid_q ? read_data_q : '0;
        assign bus.sb_ready      = 1'b1;

endmodule

`default_nettype wire

// ==== verilog/register_bank.sv ====
// Simplebus register bank slave with eight 32-bit words.
// Words 0 to 6 are read/write; word 7 counts accepted write strobes.

`default_nettype none

module register_bank (
        input logic clock,
        input logic rst,
        simplebus_if.slave bus
);
        import simplebus_pkg::*;

        logic [BUS_WIDTH-1:0]       regs [REG_COUNT-1];
        logic [BUS_WIDTH-1:0]       write_count;
        logic [REG_INDEX_WIDTH-1:0] index;
        logic [BUS_WIDTH-1:0]       read_data_q;
        logic                       read_valid_q;

        assign index = bus.sb_address[2 +: REG_INDEX_WIDTH];

        always_ff @(posedge clock) begin
                if (rst) begin
                        for (int i = 0; i < REG_COUNT - 1; i++) begin
                                regs[i] <= '0;
                        end
                        write_count <= '0;
                end else if (bus.sb_write_strobe) begin
                        // Writes to the counter word are dropped but still counted
                        if (index != REG_INDEX_WIDTH'(REG_COUNT - 1)) begin
                                regs[index] <= bus.sb_write_data;
                        end
                        write_count <= write_count + 1'b1;
                end
        end

        always_ff @(posedge clock) begin
                if (rst) begin
                        read_valid_q <= 1'b0;
                end else begin
                        read_valid_q <= bus.sb_read_strobe;
                end
        end

        always_ff @(posedge clock) begin
                if (bus.sb_read_strobe) begin
                        read_data_q <= (index == REG_INDEX_WIDTH'(REG_COUNT - 1)) ?
                                       write_count : regs[index];
                end
        end

        assign bus.sb_read_valid = read_valid_q;
        assign bus.sb_read_data  = read_valid_q ? read_data_q : '0;
        assign bus.sb_ready      = 1'b1;

endmodule

`default_nettype wire

// ==== verilog/bus_command_port.sv ====
// Four-phase req/ack command port acting as the Simplebus master.
// Each command becomes one strobe; reads wait for data before ack,
// writes are posted and acknowledged right after the strobe.

`default_nettype none

module bus_command_port (
        input  logic                                clock,
        input  logic                                rst,
        input  logic                                cmd_req,
        input  logic                                cmd_write,
        input  logic [simplebus_pkg::BUS_WIDTH-1:0] cmd_address,
        input  logic [simplebus_pkg::BUS_WIDTH-1:0] cmd_write_data,
        output logic                                cmd_ack,
        output logic [simplebus_pkg::BUS_WIDTH-1:0] cmd_read_data,
        simplebus_if.master                         bus
);
        import simplebus_pkg::*;

        cmd_state_t state;
        cmd_state_t next_state;
        logic       issue_now;

        always_ff @(posedge clock) begin
                if (rst) begin
                        state <= IDLE;
                end else begin
                        state <= next_state;
                end
        end

        always_comb begin
                next_state = state;
                case (state)
                        IDLE: begin
                                if (cmd_req) begin
                                        next_state = ISSUE;
                                end
                        end
                        ISSUE: begin
                                // Stall here while the interconnect is not ready
                                if (bus.sb_ready) begin
                                        next_state = cmd_write ? DONE : WAIT_DATA;
                                end
                        end
                        WAIT_DATA: begin
                                if (bus.sb_read_valid) begin
                                        next_state = DONE;
                                end
                        end
                        DONE: begin
                                if (!cmd_req) begin
                                        next_state = IDLE;
                                end
                        end
                        default: next_state = IDLE;
                endcase
        end

        assign issue_now = (state == ISSUE) && bus.sb_ready;

        // Agent holds the command fields stable for the whole handshake
        assign bus.sb_address      = cmd_address;
        assign bus.sb_write_data   = cmd_write_data;
        assign bus.sb_write_strobe = issue_now && cmd_write;
        assign bus.sb_read_strobe  = issue_now && !cmd_write;

        always_ff @(posedge clock) begin
                if ((state == WAIT_DATA) && bus.sb_read_valid) begin
                        cmd_read_data <= bus.sb_read_data;
                end
        end

        assign cmd_ack = (state == DONE);

        a_ack_needs_req: assert property (
                @(posedge clock) disable iff (rst) $rose(cmd_ack) |-> cmd_req
        );

        // A response may only arrive for the read being waited on
        a_valid_while_waiting: assert property (
                @(posedge clock) disable iff (rst)
                bus.sb_read_valid |-> (state == WAIT_DATA)
        );

endmodule

`default_nettype wire

// ==== verilog/simplebus_interconnect.sv ====
// One-master Simplebus interconnect with a registered address decoder.
// Requests go to the slave whose window holds the address; responses are
// merged and registered back to the master. Misses return an error word.

`default_nettype none

module simplebus_interconnect (
        input logic clock,
        input logic rst,
        simplebus_if.slave master,
        simplebus_if.master slaves [simplebus_pkg::SLAVE_COUNT]
);
        import simplebus_pkg::*;

        logic [SLAVE_COUNT-1:0] hit;
        logic                   miss;
        logic [BUS_WIDTH-1:0]   slave_read_data [SLAVE_COUNT];
        logic [SLAVE_COUNT-1:0] slave_read_valid;
        logic [SLAVE_COUNT-1:0] slave_ready;
        logic [SLAVE_COUNT-1:0] slave_strobe;
        logic                   miss_read_q;
        logic                   miss_read_q2;
        logic [BUS_WIDTH-1:0]   merged_data;
        logic                   merged_valid;

        always_comb begin
                for (int i = 0; i < SLAVE_COUNT; i++) begin
                        hit[i] = (master.sb_address >= SLAVE_LOW[i]) &&
                                 (master.sb_address < SLAVE_HIGH[i]);
                end
        end

        assign miss = ~|hit;

        for (genvar i = 0; i < SLAVE_COUNT; i++) begin : g_slave
                always_ff @(posedge clock) begin
                        if (rst) begin
                                slaves[i].sb_write_strobe <= 1'b0;
                                slaves[i].sb_read_strobe  <= 1'b0;
                        end else begin
                                slaves[i].sb_write_strobe <= master.sb_write_strobe & hit[i];
                                slaves[i].sb_read_strobe  <= master.sb_read_strobe & hit[i];
                        end
                end

                // Non-selected slaves see an all-zero request
                always_ff @(posedge clock) begin
                        slaves[i].sb_address    <= hit[i] ? master.sb_address : '0;
                        slaves[i].sb_write_data <= hit[i] ? master.sb_write_data : '0;
                end

                assign slave_read_data[i]  = slaves[i].sb_read_data;
                assign slave_read_valid[i] = slaves[i].sb_read_valid;
                assign slave_ready[i]      = slaves[i].sb_ready;
                assign slave_strobe[i]     = slaves[i].sb_write_strobe |
                                             slaves[i].sb_read_strobe;
        end

        // Error word enters the merge at the same stage as slave read data
        always_comb begin
                merged_data  = miss_read_q2 ? DECODE_ERROR_DATA : '0;
                merged_valid = miss_read_q2;
                for (int i = 0; i < SLAVE_COUNT; i++) begin
                        merged_data  = merged_data | slave_read_data[i];
                        merged_valid = merged_valid | slave_read_valid[i];
                end
        end

        // Miss flag is delayed twice to mirror the slave request and response stages
        always_ff @(posedge clock) begin
                if (rst) begin
                        miss_read_q          <= 1'b0;
                        miss_read_q2         <= 1'b0;
                        master.sb_read_valid <= 1'b0;
                        master.sb_ready      <= 1'b0;
                end else begin
                        miss_read_q          <= master.sb_read_strobe & miss;
                        miss_read_q2         <= miss_read_q;
                        master.sb_read_valid <= merged_valid;
                        master.sb_ready      <= &slave_ready;
                end
        end

        always_ff @(posedge clock) begin
                master.sb_read_data <= merged_data;
        end

        // Windows do not overlap, so only one slave may be addressed at a time
        a_one_slave_strobe: assert property (
                @(posedge clock) disable iff (rst) $onehot0(slave_strobe)
        );

endmodule

`default_nettype wire

// ==== verilog/simplebus_if.sv ====
// Simplebus connection between one master and one slave.
// The master modport drives the request, the slave modport the response.

`default_nettype none

interface simplebus_if;
        import simplebus_pkg::*;

        logic [BUS_WIDTH-1:0] sb_address;
        logic [BUS_WIDTH-1:0] sb_write_data;
        logic                 sb_write_strobe;
        logic                 sb_read_strobe;
        logic [BUS_WIDTH-1:0] sb_read_data;
        logic                 sb_read_valid;
        logic                 sb_ready;

        modport master (
                output sb_address,
                output sb_write_data,
                output sb_write_strobe,
                output sb_read_strobe,
                input  sb_read_data,
                input  sb_read_valid,
                input  sb_ready
        );

        modport slave (
                input  sb_address,
                input  sb_write_data,
                input  sb_write_strobe,
                input  sb_read_strobe,
                output sb_read_data,
                output sb_read_valid,
                output sb_ready
        );

endinterface

`default_nettype wire

// ==== verilog/simplebus_pkg.sv ====
// Shared constants and types for the Simplebus peripheral subsystem.
// Holds the bus width, the slave address map and the command-port states.
// Compile before every other design file.

`default_nettype none

package simplebus_pkg;

        localparam int BUS_WIDTH = 32;

        // Number of slave windows on the interconnect
        localparam int SLAVE_COUNT = 2;

        // Register bank window, eight words
        localparam logic [BUS_WIDTH-1:0] REGBANK_LOW  = 32'h0000_0000;
        localparam logic [BUS_WIDTH-1:0] REGBANK_HIGH = 32'h0000_0020;

        // Scratch RAM window, 256 words
        localparam logic [BUS_WIDTH-1:0] RAM_LOW  = 32'h0000_1000;
        localparam logic [BUS_WIDTH-1:0] RAM_HIGH = 32'h0000_1400;

        // Slot 0 is the register bank, slot 1 the RAM
        localparam logic [BUS_WIDTH-1:0] SLAVE_LOW [SLAVE_COUNT] = '{REGBANK_LOW, RAM_LOW};
        localparam logic [BUS_WIDTH-1:0] SLAVE_HIGH [SLAVE_COUNT] = '{REGBANK_HIGH, RAM_HIGH};

        // Read data returned for an address outside every window
        localparam logic [BUS_WIDTH-1:0] DECODE_ERROR_DATA = 32'hdead_beef;

        // Last register word is the write counter
        localparam int REG_COUNT = 8;
        localparam int REG_INDEX_WIDTH = $clog2(REG_COUNT);

        localparam int RAM_DEPTH = 256;
        localparam int RAM_INDEX_WIDTH = $clog2(RAM_DEPTH);

        typedef enum logic [1:0] {
                IDLE,
                ISSUE,
                WAIT_DATA,
                DONE
        } cmd_state_t;

endpackage

`default_nettype wire
